/* Makefile */
VERILATOR ?= verilator
TOP       ?= vrc_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/vrc_tb_check.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || \
		(echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/vrc_tb_check.svh */
// model state, stepped once per falling edge
logic       m_mode;
logic       m_enable;
logic       m_eaa;
logic       m_pending;
logic [7:0] m_latch;
logic [7:0] m_counter;
logic [8:0] m_pre;
logic [3:0] m_bank16;
logic [4:0] m_bank8;
// decoded write waiting for the next edge
logic       c_latch, c_ctrl, c_ack, c_b16, c_b8;
logic [7:0] c_data;

task automatic model_step(input logic rst, input sst_bus_t s, input cpu_addr_t a,
                          input logic [7:0] d, input logic we);
    logic wr;
    logic tap;
    if (rst) begin
        {m_mode, m_enable, m_eaa, m_pending} = '0;
        m_counter = 0;
        m_pre = 0;
        m_bank16 = 0;
        m_bank8 = 0;
    end else if (s.enable) begin
        if (s.we) begin
            case (s.addr)
                0:  m_bank16 = s.wdata[3:0];
                1:  m_bank8 = s.wdata[4:0];
                16: {m_pending, m_mode, m_enable, m_eaa} = s.wdata[3:0];
                17: m_latch = s.wdata;
                18: m_counter = s.wdata;
                19: m_pre[7:0] = s.wdata;
                20: m_pre[8] = s.wdata[0];
                default: ;
            endcase
        end
    end else begin
        tap = m_pre == 113 || m_pre == 227 || m_pre == 340;
        if (m_enable) begin
            if (m_mode || tap) begin
                if (m_counter == 8'hff) begin
                    m_counter = m_latch;
                    m_pending = 1;
                end else begin
                    m_counter = m_counter + 1;
                end
            end
            m_pre = (m_pre == 340) ? 0 : m_pre + 1;
        end
        if (c_latch) begin
            m_latch = c_data;
        end else if (c_ctrl) begin
            {m_mode, m_enable, m_eaa} = c_data[2:0];
            if (c_data[1]) begin
                m_counter = m_latch;
                m_pre = 0;
            end
        end else if (c_ack) begin
            m_pending = 0;
            m_enable = m_eaa;
        end
        if (c_b16) m_bank16 = c_data[3:0];
        if (c_b8) m_bank8 = c_data[4:0];
    end
    // register decode, mirrored on A15:A12 and A1:A0
    wr = we && !s.enable && !rst;
    c_data = d;
    c_b16 = wr && a[15:12] == 4'h8;
    c_b8 = wr && a[15:12] == 4'hc;
    c_latch = wr && a[15:12] == 4'hf && a[1:0] == 0;
    c_ctrl = wr && a[15:12] == 4'hf && a[1:0] == 1;
    c_ack = wr && a[15:12] == 4'hf && a[1:0] == 2;
endtask

function automatic logic [7:0] model_read(input logic [5:0] addr);
    case (addr)
        0:  return {4'h0, m_bank16};
        1:  return {3'h0, m_bank8};
        16: return {4'h0, m_pending, m_mode, m_enable, m_eaa};
        17: return m_latch;
        18: return m_counter;
        19: return m_pre[7:0];
        20: return {7'h0, m_pre[8]};
        default: return 8'hff;
    endcase
endfunction

function automatic prg_addr_t ref_map(input cpu_addr_t a, input logic [3:0] b16,
                                      input logic [4:0] b8);
    if (a >= 16'h8000 && a < 16'hc000) return {b16, a[13:0]};
    if (a >= 16'hc000 && a < 16'he000) return {b8, a[12:0]};
    if (a >= 16'he000) return {5'd31, a[12:0]};
    return '0;
endfunction

task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
        $display("mismatch irq: got %h expected %h at %0t", got, exp, $time);
        errors++;
    end
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("mismatch sst_rdata: got %h expected %h at %0t", got, exp, $time);
        errors++;
    end
endtask

task automatic check_prg(input prg_addr_t got, input prg_addr_t exp);
    if (got !== exp) begin
        $display("mismatch prg_addr: got %h expected %h at %0t", got, exp, $time);
        errors++;
    end
endtask

/* bench/vrc_tb.sv */
module vrc_tb import vrc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    // cycle budgets of reset and tests 1 to 5, plus margin
    localparam int BUDGET = 20 + 20 + 400 + 700 + 300 + 600 + 500;

    logic       clk;
    logic       reset;
    cpu_addr_t  cpu_addr;
    logic [7:0] cpu_wdata;
    logic       cpu_we;
    sst_bus_t   sst;
    prg_addr_t  prg_addr;
    logic       irq;
    logic [7:0] sst_rdata;

    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    integer seed = 32'he814;

    `include "vrc_tb_check.svh"

    vrc_mapper dut_i (
        .clk       (clk),
        .reset     (reset),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .sst       (sst),
        .prg_addr  (prg_addr),
        .irq       (irq),
        .sst_rdata (sst_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        model_step(reset, sst, cpu_addr, cpu_wdata, cpu_we);
    end

    // compare process
    always @(posedge clk) begin
        if (!reset) begin
            check_irq(irq, !(m_pending && m_enable));
            check_byte(sst_rdata, model_read(sst.addr));
            check_prg(prg_addr, ref_map(cpu_addr, m_bank16, m_bank8));
        end
    end

    initial begin
        #(BUDGET * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic cpu_write(input cpu_addr_t a, input logic [7:0] d);
        @(posedge clk);
        #1;
        cpu_addr = a;
        cpu_wdata = d;
        cpu_we = 1'b1;
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    // the port stays enabled until sst_release
    task automatic sst_write(input logic [5:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        sst = '{enable: 1'b1, we: 1'b1, addr: a, wdata: d};
        @(posedge clk);
        #1;
        sst.we = 1'b0;
    endtask

    task automatic sst_read(input logic [5:0] a, input logic [7:0] exp);
        @(posedge clk);
        #1;
        sst = '{enable: 1'b1, we: 1'b0, addr: a, wdata: 8'h00};
        #1;
        check_byte(sst_rdata, exp);
    endtask

    task automatic sst_release();
        @(posedge clk);
        #1;
        sst.enable = 1'b0;
        sst.we = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_irq_low(input int limit);
        int n;
        n = 0;
        while (irq !== 1'b0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (irq !== 1'b0) begin
            $display("irq did not assert within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [7:0] v [0:6];
        logic [5:0] sa [0:6];
        logic [7:0] mask [0:6];
        cpu_addr_t a;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_we = 1'b0;
        sst = '{enable: 1'b0, we: 1'b0, addr: 6'd16, wdata: 8'h00};
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        check_irq(irq, 1'b1);
        sst_read(6'd16, 8'h00);
        sst_read(6'd30, 8'hff);
        sst_release();
        finish_test("reset");

        // enable-after-ack clear, so the acknowledge stops counting
        sst.addr = 6'd18;
        cpu_write(ADDR_IRQ_LATCH, 8'($random(seed)) | 8'h80);
        cpu_write(ADDR_IRQ_CTRL, 8'h06);
        wait_irq_low(300);
        idle(3);
        cpu_write(ADDR_IRQ_ACK, 8'h00);
        idle(2);
        check_irq(irq, 1'b1);
        idle(20);
        finish_test("cycle_irq");

        sst.addr = 6'd19;
        cpu_write(ADDR_IRQ_LATCH, 8'hfe);
        cpu_write(ADDR_IRQ_CTRL, 8'h02);
        idle(200);
        sst.addr = 6'd18;
        wait_irq_low(400);
        sst.addr = 6'd20;
        idle(150);
        sst.addr = 6'd19;
        cpu_write(ADDR_IRQ_ACK, 8'h00);
        idle(10);
        finish_test("scanline_irq");

        cpu_write(16'h8000 | 16'($random(seed) & 3), 8'($random(seed)));
        cpu_write(16'hc000 | 16'($random(seed) & 3), 8'($random(seed)));
        idle(2);
        for (int i = 0; i < 60; i++) begin
            a = 16'($random(seed));
            case (i % 4)
                0: a = 16'h8000 | (a & 16'h3fff);
                1: a = 16'hc000 | (a & 16'h1fff);
                2: a = 16'he000 | (a & 16'h1fff);
                default: a = a & 16'h7fff;
            endcase
            @(posedge clk);
            #1;
            cpu_addr = a;
            #1;
            check_prg(prg_addr, ref_map(a, m_bank16, m_bank8));
        end
        finish_test("prg_map");

        sa = '{6'd0, 6'd1, 6'd16, 6'd17, 6'd18, 6'd19, 6'd20};
        mask = '{8'h0f, 8'h1f, 8'h0f, 8'hff, 8'hff, 8'hff, 8'h01};
        for (int i = 0; i < 7; i++) begin
            v[i] = 8'($random(seed)) & mask[i];
        end
        // keep enable and cycle mode set and the prescaler in its 341-step range
        v[2] = v[2] | 8'h06;
        if (v[6][0]) begin
            v[5] = v[5] % 85;
        end
        for (int i = 0; i < 7; i++) begin
            sst_write(sa[i], v[i]);
        end
        for (int i = 0; i < 7; i++) begin
            sst_read(sa[i], v[i]);
        end
        // hold the port enabled, the counter must not move
        @(posedge clk);
        #1;
        sst = '{enable: 1'b1, we: 1'b0, addr: 6'd18, wdata: 8'h00};
        repeat (6) begin
            @(posedge clk);
            #1;
            check_byte(sst_rdata, v[4]);
        end
        sst.enable = 1'b0;
        idle(400);
        finish_test("save_state");

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* hw/vrc_irq.sv */
module vrc_irq import vrc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  irq_cmd_t   irq_cmd,
    input  sst_bus_t   sst,
    output logic       irq,
    output logic [7:0] sst_rdata
);

    logic                  mode;
    logic                  enable;
    logic                  enable_after_ack;
    logic                  pending;
    logic [7:0]            latch;
    logic [7:0]            counter;
    logic [PRESCALE_W-1:0] prescaler;

    logic                  sst_wr;
    logic                  at_tap;
    logic                  step;
    logic                  counter_wrap;
    logic [PRESCALE_W-1:0] prescaler_next;

    assign sst_wr = sst.enable && sst.we;

    // three counter clocks per 341-dot line
    assign at_tap = prescaler == PRESCALE_TAP0 ||
                    prescaler == PRESCALE_TAP1 ||
                    prescaler == PRESCALE_LAST;

    // cycle mode steps on every edge
    assign step = mode || at_tap;

    assign counter_wrap = counter == 8'hFF;

    assign prescaler_next = (prescaler == PRESCALE_LAST) ? '0 : prescaler + 1'b1;

    // active low line to the CPU
    assign irq = !(pending && enable);

    always_ff @(negedge clk) begin
        if (reset) begin
            mode             <= 1'b0;
            enable           <= 1'b0;
            enable_after_ack <= 1'b0;
            pending          <= 1'b0;
            counter          <= '0;
            prescaler        <= '0;
        end else if (sst.enable) begin
            if (sst_wr) begin
                case (sst.addr)
                    SST_IRQ_CTRL: begin
                        {pending, mode, enable, enable_after_ack} <= sst.wdata[3:0];
                    end
                    SST_IRQ_LATCH:  latch           <= sst.wdata;
                    SST_IRQ_COUNT:  counter         <= sst.wdata;
                    SST_IRQ_PRE_LO: prescaler[7:0]  <= sst.wdata;
                    SST_IRQ_PRE_HI: prescaler[8]    <= sst.wdata[0];
                    default: ;
                endcase
            end
        end else begin
            if (enable) begin
                prescaler <= prescaler_next;
                if (step) begin
                    counter <= counter_wrap ? latch : counter + 1'b1;
                    if (counter_wrap) begin
                        pending <= 1'b1;
                    end
                end
            end

            // CPU writes win over counting in the same edge
            if (irq_cmd.latch_we) begin
                latch <= irq_cmd.data;
            end else if (irq_cmd.ctrl_we) begin
                {mode, enable, enable_after_ack} <= irq_cmd.data[2:0];
                // enabling restarts from the latch
                if (irq_cmd.data[1]) begin
                    counter   <= latch;
                    prescaler <= '0;
                end
            end else if (irq_cmd.ack) begin
                pending <= 1'b0;
                enable  <= enable_after_ack;
            end
        end
    end

    always_comb begin
        case (sst.addr)
            SST_IRQ_CTRL:   sst_rdata = {4'b0, pending, mode, enable, enable_after_ack};
            SST_IRQ_LATCH:  sst_rdata = latch;
            SST_IRQ_COUNT:  sst_rdata = counter;
            SST_IRQ_PRE_LO: sst_rdata = prescaler[7:0];
            SST_IRQ_PRE_HI: sst_rdata = {7'b0, prescaler[8]};
            default:        sst_rdata = 8'hFF;
        endcase
    end

    // the three taps assume a 341-step prescaler
    prescaler_in_range: assert property (
        @(negedge clk) disable iff (reset)
        prescaler <= PRESCALE_LAST
    ) else $error("prescaler ran past %0d", PRESCALE_LAST);

endmodule

/* hw/vrc_mapper.sv */
module vrc_mapper import vrc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  cpu_addr_t  cpu_addr,
    input  logic [7:0] cpu_wdata,
    input  logic       cpu_we,
    input  sst_bus_t   sst,
    output prg_addr_t  prg_addr,
    output logic       irq,
    output logic [7:0] sst_rdata
);

    irq_cmd_t   irq_cmd;
    prg_cmd_t   prg_cmd;
    prg_regs_t  prg_regs;
    logic [7:0] irq_sst_rdata;

    vrc_reg_decode decode_i (
        .clk        (clk),
        .reset      (reset),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_we     (cpu_we),
        .sst_active (sst.enable),
        .irq_cmd    (irq_cmd),
        .prg_cmd    (prg_cmd)
    );

    vrc_irq irq_i (
        .clk       (clk),
        .reset     (reset),
        .irq_cmd   (irq_cmd),
        .sst       (sst),
        .irq       (irq),
        .sst_rdata (irq_sst_rdata)
    );

    // end of the save-state read chain
    vrc_prg_bank bank_i (
        .clk           (clk),
        .reset         (reset),
        .prg_cmd       (prg_cmd),
        .sst           (sst),
        .irq_sst_rdata (irq_sst_rdata),
        .prg_regs      (prg_regs),
        .sst_rdata     (sst_rdata)
    );

    vrc_prg_map map_i (
        .cpu_addr (cpu_addr),
        .prg_regs (prg_regs),
        .prg_addr (prg_addr)
    );

endmodule

/* hw/vrc_pkg.sv */
package vrc_pkg;

    // bus and ROM widths
    localparam int CPU_ADDR_W   = 16;
    localparam int PRG_ADDR_W   = 18;
    localparam int PRG_BANK16_W = 4;
    localparam int PRG_BANK8_W  = 5;
    localparam int SST_ADDR_W   = 6;
    localparam int PRESCALE_W   = 9;

    typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
    typedef logic [PRG_ADDR_W-1:0] prg_addr_t;

    // one decoded IRQ register write
    typedef struct packed {
        logic       latch_we;
        logic       ctrl_we;
        logic       ack;
        logic [7:0] data;
    } irq_cmd_t;

    // one decoded PRG bank write
    typedef struct packed {
        logic       bank16_we;
        logic       bank8_we;
        logic [7:0] data;
    } prg_cmd_t;

    typedef struct packed {
        logic [PRG_BANK16_W-1:0] bank16;
        logic [PRG_BANK8_W-1:0]  bank8;
    } prg_regs_t;

    // save-state request
    typedef struct packed {
        logic                  enable;
        logic                  we;
        logic [SST_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } sst_bus_t;

    // CPU register map
    localparam cpu_addr_t ADDR_PRG16     = 16'h8000;
    localparam cpu_addr_t ADDR_PRG8      = 16'hC000;
    localparam cpu_addr_t ADDR_IRQ_LATCH = 16'hF000;
    localparam cpu_addr_t ADDR_IRQ_CTRL  = 16'hF001;
    localparam cpu_addr_t ADDR_IRQ_ACK   = 16'hF002;

    // save-state map
    localparam logic [SST_ADDR_W-1:0] SST_PRG16      = 6'd0;
    localparam logic [SST_ADDR_W-1:0] SST_PRG8       = 6'd1;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_CTRL   = 6'd16;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_LATCH  = 6'd17;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_COUNT  = 6'd18;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_PRE_LO = 6'd19;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_PRE_HI = 6'd20;

    // scanline prescaler, 341 steps with three taps per line
    localparam logic [PRESCALE_W-1:0] PRESCALE_TAP0 = 9'd113;
    localparam logic [PRESCALE_W-1:0] PRESCALE_TAP1 = 9'd227;
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = 9'd340;

    localparam logic [PRG_BANK8_W-1:0] PRG_LAST_BANK8 = 5'd31;

endpackage

/* hw/vrc_prg_bank.sv */
module vrc_prg_bank import vrc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  prg_cmd_t   prg_cmd,
    input  sst_bus_t   sst,
    input  logic [7:0] irq_sst_rdata,
    output prg_regs_t  prg_regs,
    output logic [7:0] sst_rdata
);

    logic sst_wr;
    logic sst_wr_prg16;
    logic sst_wr_prg8;

    assign sst_wr       = sst.enable && sst.we;
    assign sst_wr_prg16 = sst_wr && sst.addr == SST_PRG16;
    assign sst_wr_prg8  = sst_wr && sst.addr == SST_PRG8;

    always_ff @(negedge clk) begin
        if (reset) begin
            prg_regs <= '0;
        end else if (sst.enable) begin
            if (sst_wr_prg16) begin
                prg_regs.bank16 <= sst.wdata[PRG_BANK16_W-1:0];
            end
            if (sst_wr_prg8) begin
                prg_regs.bank8 <= sst.wdata[PRG_BANK8_W-1:0];
            end
        end else begin
            // upper data bits are not wired on the cartridge
            if (prg_cmd.bank16_we) begin
                prg_regs.bank16 <= prg_cmd.data[PRG_BANK16_W-1:0];
            end
            if (prg_cmd.bank8_we) begin
                prg_regs.bank8 <= prg_cmd.data[PRG_BANK8_W-1:0];
            end
        end
    end

    // own bytes first, everything else comes from the IRQ block
    always_comb begin
        case (sst.addr)
            SST_PRG16: sst_rdata = 8'(prg_regs.bank16);
            SST_PRG8:  sst_rdata = 8'(prg_regs.bank8);
            default:   sst_rdata = irq_sst_rdata;
        endcase
    end

endmodule

/* hw/vrc_prg_map.sv */
module vrc_prg_map import vrc_pkg::*; (
    input  cpu_addr_t cpu_addr,
    input  prg_regs_t prg_regs,
    output prg_addr_t prg_addr
);

    logic in_bank16;
    logic in_bank8;
    logic in_fixed;

    // $8000-$BFFF
    assign in_bank16 = cpu_addr[15:14] == ADDR_PRG16[15:14];
    // $C000-$DFFF
    assign in_bank8  = cpu_addr[15:13] == ADDR_PRG8[15:13];
    // $E000-$FFFF is hardwired to the last 8 KB
    assign in_fixed  = cpu_addr[15:13] == 3'b111;

    always_comb begin
        if (in_bank16) begin
            prg_addr = {prg_regs.bank16, cpu_addr[13:0]};
        end else if (in_bank8) begin
            prg_addr = {prg_regs.bank8, cpu_addr[12:0]};
        end else if (in_fixed) begin
            prg_addr = {PRG_LAST_BANK8, cpu_addr[12:0]};
        end else begin
            // below $8000 is not PRG ROM
            prg_addr = '0;
        end
    end

endmodule

/* hw/vrc_reg_decode.sv */
module vrc_reg_decode import vrc_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  cpu_addr_t cpu_addr,
    input  logic [7:0] cpu_wdata,
    input  logic      cpu_we,
    input  logic      sst_active,
    output irq_cmd_t  irq_cmd,
    output prg_cmd_t  prg_cmd
);

    logic wr_ok;
    logic hi_prg16;
    logic hi_prg8;
    logic hi_irq;
    logic hit_prg16;
    logic hit_prg8;
    logic hit_latch;
    logic hit_ctrl;
    logic hit_ack;

    // writes are dropped while a save-state access runs
    assign wr_ok = cpu_we && !sst_active;

    // VRC6 only looks at A15:A12 and A1:A0
    assign hi_prg16 = cpu_addr[15:12] == ADDR_PRG16[15:12];
    assign hi_prg8  = cpu_addr[15:12] == ADDR_PRG8[15:12];
    assign hi_irq   = cpu_addr[15:12] == ADDR_IRQ_LATCH[15:12];

    // bank selects mirror over all four low slots
    assign hit_prg16 = wr_ok && hi_prg16;
    assign hit_prg8  = wr_ok && hi_prg8;

    assign hit_latch = wr_ok && hi_irq && cpu_addr[1:0] == ADDR_IRQ_LATCH[1:0];
    assign hit_ctrl  = wr_ok && hi_irq && cpu_addr[1:0] == ADDR_IRQ_CTRL[1:0];
    assign hit_ack   = wr_ok && hi_irq && cpu_addr[1:0] == ADDR_IRQ_ACK[1:0];

    always_ff @(negedge clk) begin
        irq_cmd.data <= cpu_wdata;
        prg_cmd.data <= cpu_wdata;
        if (reset) begin
            irq_cmd.latch_we  <= 1'b0;
            irq_cmd.ctrl_we   <= 1'b0;
            irq_cmd.ack       <= 1'b0;
            prg_cmd.bank16_we <= 1'b0;
            prg_cmd.bank8_we  <= 1'b0;
        end else begin
            irq_cmd.latch_we  <= hit_latch;
            irq_cmd.ctrl_we   <= hit_ctrl;
            irq_cmd.ack       <= hit_ack;
            prg_cmd.bank16_we <= hit_prg16;
            prg_cmd.bank8_we  <= hit_prg8;
        end
    end

    // the IRQ block applies latch before ctrl before ack, so overlap would lose a write
    one_cmd_per_cycle: assert property (
        @(negedge clk) disable iff (reset)
        $onehot0({irq_cmd.latch_we, irq_cmd.ctrl_we, irq_cmd.ack,
                  prg_cmd.bank16_we, prg_cmd.bank8_we})
    ) else $error("more than one register command in a cycle");

endmodule

/* list.f */
+incdir+bench
hw/vrc_pkg.sv
hw/vrc_reg_decode.sv
hw/vrc_irq.sv
hw/vrc_prg_bank.sv
hw/vrc_prg_map.sv
hw/vrc_mapper.sv
bench/vrc_tb.sv
